//--- hw/cache_sim_defines.svh
// Cache geometry, address split, queue depth and counter width macros
`ifndef CACHE_SIM_DEFINES_SVH
`define CACHE_SIM_DEFINES_SVH

// Set count and address split
`define CS_SETS        16
`define CS_INDEX_BITS  4
`define CS_OFFSET_BITS 6
`define CS_ADDR_BITS   32
// Tag is whatever is left above index and offset
`define CS_TAG_BITS    22

// Ways per cache
`define CS_D_WAYS      8
`define CS_I_WAYS      4
// LRU age width, enough to rank 8 ways
`define CS_LRU_BITS    3

// Command queue depth, equal to the host credit pool
`define CS_CMD_CREDITS 4
`define CS_CNT_BITS    16

`endif

//--- hw/cache_sim_pkg.sv
// Opcode, MESI state and controller state enums
package cache_sim_pkg;

    // Trace command opcodes
    typedef enum logic [3:0] {
        CMD_RD_DATA = 4'd0,
        CMD_WR_DATA = 4'd1,
        CMD_FETCH   = 4'd2,
        // Snoops from another agent
        CMD_SNP_INV = 4'd3,
        CMD_SNP_RD  = 4'd4,
        // Reset both caches
        CMD_CLEAR   = 4'd8
    } cmd_op_e;

    // Line coherence states
    typedef enum logic [1:0] {
        MESI_I = 2'd0,
        MESI_S = 2'd1,
        MESI_E = 2'd2,
        MESI_M = 2'd3
    } mesi_e;

    // Access controller FSM
    typedef enum logic [1:0] {
        ST_IDLE   = 2'd0,
        ST_LOOKUP = 2'd1,
        ST_UPDATE = 2'd2,
        ST_CLEAR  = 2'd3
    } ctrl_state_e;

endpackage

//--- hw/cmd_decoder.sv
// Credit-managed command queue with tag and set index split
`timescale 1ns/1ps
`include "cache_sim_defines.svh"

module cmd_decoder import cache_sim_pkg::*; (
    input  logic                      clk,
    input  logic                      rst_n_i,
    input  logic                      cmd_valid_i,
    input  cmd_op_e                   cmd_op_i,
    input  logic [`CS_ADDR_BITS-1:0]  cmd_addr_i,
    input  logic                      dec_pop_i,
    output logic                      dec_valid_o,
    output cmd_op_e                   dec_op_o,
    output logic [`CS_TAG_BITS-1:0]   dec_tag_o,
    output logic [`CS_INDEX_BITS-1:0] dec_index_o,
    output logic                      cmd_credit_o
);
    localparam int PTR_BITS = $clog2(`CS_CMD_CREDITS);

    // Queue storage, offset bits are dropped on entry
    cmd_op_e                   op_q  [`CS_CMD_CREDITS];
    logic [`CS_TAG_BITS-1:0]   tag_q [`CS_CMD_CREDITS];
    logic [`CS_INDEX_BITS-1:0] idx_q [`CS_CMD_CREDITS];

    logic [PTR_BITS-1:0] wr_ptr_q;
    logic [PTR_BITS-1:0] rd_ptr_q;
    logic [PTR_BITS:0]   count_q;

    // Wrap at queue depth
    function automatic logic [PTR_BITS-1:0] ptr_inc(input logic [PTR_BITS-1:0] p);
        return (p == PTR_BITS'(`CS_CMD_CREDITS - 1)) ? '0 : p + 1'b1;
    endfunction

    always_ff @(posedge clk) begin
        if (cmd_valid_i) begin
            op_q[wr_ptr_q]  <= cmd_op_i;
            tag_q[wr_ptr_q] <= cmd_addr_i[`CS_ADDR_BITS-1 -: `CS_TAG_BITS];
            idx_q[wr_ptr_q] <= cmd_addr_i[`CS_OFFSET_BITS +: `CS_INDEX_BITS];
        end
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            wr_ptr_q     <= '0;
            rd_ptr_q     <= '0;
            count_q      <= '0;
            cmd_credit_o <= 1'b0;
        end else begin
            if (cmd_valid_i)
                wr_ptr_q <= ptr_inc(wr_ptr_q);
            if (dec_pop_i)
                rd_ptr_q <= ptr_inc(rd_ptr_q);
            count_q <= count_q + (PTR_BITS+1)'(cmd_valid_i) - (PTR_BITS+1)'(dec_pop_i);
            // One credit back per entry handed to execute
            cmd_credit_o <= dec_pop_i;
        end
    end

    // Head of queue, valid whenever not empty
    assign dec_valid_o = (count_q != '0);
    assign dec_op_o    = op_q[rd_ptr_q];
    assign dec_tag_o   = tag_q[rd_ptr_q];
    assign dec_index_o = idx_q[rd_ptr_q];

    // Host sent without a credit
    a_no_push_full: assert property (@(posedge clk) disable iff (!rst_n_i)
        cmd_valid_i |-> (count_q < `CS_CMD_CREDITS))
        else $error("command pushed into full queue");

    // Controller popped an empty queue
    a_no_pop_empty: assert property (@(posedge clk) disable iff (!rst_n_i)
        dec_pop_i |-> dec_valid_o)
        else $error("pop from empty command queue");

endmodule

//--- hw/lru_way_select.sv
// Hit detection, victim way choice and LRU age update for one cache set
`timescale 1ns/1ps
`include "cache_sim_defines.svh"

module lru_way_select import cache_sim_pkg::*; #(
    parameter int WAYS = 8
) (
    input  cmd_op_e                                op_i,
    input  logic [`CS_TAG_BITS-1:0]                req_tag_i,
    input  logic [WAYS-1:0][`CS_TAG_BITS-1:0]      ways_tag_i,
    input  mesi_e [WAYS-1:0]                       ways_mesi_i,
    input  logic [WAYS-1:0][`CS_LRU_BITS-1:0]      ways_lru_i,
    output logic                                   hit_o,
    output logic [$clog2(WAYS)-1:0]                way_o,
    output logic [WAYS-1:0][`CS_LRU_BITS-1:0]      lru_next_o
);
    localparam int WAY_BITS = $clog2(WAYS);

    logic [WAYS-1:0]          match;
    logic [WAY_BITS-1:0]      hit_way;
    logic                     inv_found;
    logic [WAY_BITS-1:0]      inv_way;
    logic [WAY_BITS-1:0]      old_way;
    logic [`CS_LRU_BITS-1:0]  thresh;

    // Hit and victim search
    always_comb begin
        match     = '0;
        hit_way   = '0;
        inv_found = 1'b0;
        inv_way   = '0;
        old_way   = '0;

        // A matching tag counts only on a valid line
        for (int w = 0; w < WAYS; w++) begin
            match[w] = (ways_mesi_i[w] != MESI_I) && (ways_tag_i[w] == req_tag_i);
            if (match[w])
                hit_way = WAY_BITS'(w);
        end

        // Scan down so the lowest invalid index wins
        for (int w = WAYS - 1; w >= 0; w--) begin
            if (ways_mesi_i[w] == MESI_I) begin
                inv_found = 1'b1;
                inv_way   = WAY_BITS'(w);
            end
        end

        // Oldest age, ties keep the lower way
        for (int w = 1; w < WAYS; w++) begin
            if (ways_lru_i[w] > ways_lru_i[old_way])
                old_way = WAY_BITS'(w);
        end

        hit_o = |match;
        if (hit_o)
            way_o = hit_way;
        else if (inv_found)
            way_o = inv_way;
        else
            way_o = old_way;
    end

    // Age update, only real accesses touch LRU
    always_comb begin
        // Old age of the used way, younger ways shift up past it
        thresh     = ways_lru_i[way_o];
        lru_next_o = ways_lru_i;
        if (op_i inside {CMD_RD_DATA, CMD_WR_DATA, CMD_FETCH}) begin
            for (int w = 0; w < WAYS; w++) begin
                if (WAY_BITS'(w) == way_o)
                    lru_next_o[w] = '0;
                else if (ways_lru_i[w] < thresh)
                    lru_next_o[w] = ways_lru_i[w] + 1'b1;
            end
        end
    end

    // A tag lives in at most one valid way of a set
    always_comb begin
        a_one_match: assert final ($onehot0(match))
            else $error("multiple valid ways match tag %h", req_tag_i);
    end

endmodule

//--- hw/mesi_next_state.sv
// Next MESI state of the selected way from opcode and hit
`timescale 1ns/1ps

module mesi_next_state import cache_sim_pkg::*; (
    input  cmd_op_e op_i,
    input  logic    hit_i,
    input  mesi_e   cur_i,
    output mesi_e   next_o
);
    always_comb begin
        next_o = cur_i;
        case (op_i)
            // No L2 bus, a fill is always exclusive
            CMD_RD_DATA, CMD_FETCH: next_o = hit_i ? cur_i : MESI_E;
            CMD_WR_DATA:            next_o = MESI_M;
            // Another agent takes the line
            CMD_SNP_INV:            next_o = MESI_I;
            CMD_SNP_RD: begin
                if (!hit_i)
                    next_o = MESI_I;
                else if (cur_i == MESI_M || cur_i == MESI_E)
                    next_o = MESI_S;
                // Shared stays shared
                else
                    next_o = cur_i;
            end
            default:                next_o = cur_i;
        endcase
    end

    // Missed snoops report no line, never a dirty one
    always_comb begin
        a_snoop_miss: assert final (!((op_i inside {CMD_SNP_INV, CMD_SNP_RD}) && !hit_i
                                      && next_o == MESI_M))
            else $error("snoop miss produced M");
    end

endmodule

//--- hw/cache_access_ctrl.sv
// Tag, MESI and LRU arrays of both caches with lookup, update and clear FSM
`timescale 1ns/1ps
`include "cache_sim_defines.svh"

module cache_access_ctrl import cache_sim_pkg::*; (
    input  logic                          clk,
    input  logic                          rst_n_i,
    input  logic                          dec_valid_i,
    input  cmd_op_e                       dec_op_i,
    input  logic [`CS_TAG_BITS-1:0]       dec_tag_i,
    input  logic [`CS_INDEX_BITS-1:0]     dec_index_i,
    output logic                          dec_pop_o,
    output logic                          ex_done_o,
    output cmd_op_e                       ex_op_o,
    output logic                          ex_hit_o,
    output logic [$clog2(`CS_D_WAYS)-1:0] ex_way_o,
    output mesi_e                         ex_mesi_o
);
    localparam int D_WB = $clog2(`CS_D_WAYS);
    localparam int I_WB = $clog2(`CS_I_WAYS);

    // Data and instruction arrays, one packed row per set
    logic [`CS_D_WAYS-1:0][`CS_TAG_BITS-1:0] d_tag  [`CS_SETS];
    mesi_e [`CS_D_WAYS-1:0]                  d_mesi [`CS_SETS];
    logic [`CS_D_WAYS-1:0][`CS_LRU_BITS-1:0] d_lru  [`CS_SETS];
    logic [`CS_I_WAYS-1:0][`CS_TAG_BITS-1:0] i_tag  [`CS_SETS];
    mesi_e [`CS_I_WAYS-1:0]                  i_mesi [`CS_SETS];
    logic [`CS_I_WAYS-1:0][`CS_LRU_BITS-1:0] i_lru  [`CS_SETS];

    ctrl_state_e state_q, state_d;
    logic [`CS_INDEX_BITS-1:0] clr_idx_q;
    logic clr_last;

    // Accepted command
    cmd_op_e                   req_op_q;
    logic [`CS_TAG_BITS-1:0]   req_tag_q;
    logic [`CS_INDEX_BITS-1:0] req_index_q;
    logic is_fetch;
    logic is_access;

    // Combinational lookup results
    logic d_hit, i_hit, sel_hit;
    logic [D_WB-1:0] d_way;
    logic [I_WB-1:0] i_way;
    logic [`CS_D_WAYS-1:0][`CS_LRU_BITS-1:0] d_lru_nx;
    logic [`CS_I_WAYS-1:0][`CS_LRU_BITS-1:0] i_lru_nx;
    mesi_e cur_mesi, mesi_nx;

    // Registered lookup, written back in ST_UPDATE
    logic hit_q;
    logic [D_WB-1:0] way_q;
    mesi_e mesi_q;
    logic [`CS_D_WAYS-1:0][`CS_LRU_BITS-1:0] d_lru_nx_q;
    logic [`CS_I_WAYS-1:0][`CS_LRU_BITS-1:0] i_lru_nx_q;

    assign is_fetch  = (req_op_q == CMD_FETCH);
    assign is_access = req_op_q inside {CMD_RD_DATA, CMD_WR_DATA, CMD_FETCH};
    assign clr_last  = (clr_idx_q == `CS_INDEX_BITS'(`CS_SETS - 1));

    lru_way_select #(.WAYS(`CS_D_WAYS)) d_sel_inst (
        .op_i(req_op_q), .req_tag_i(req_tag_q),
        .ways_tag_i(d_tag[req_index_q]), .ways_mesi_i(d_mesi[req_index_q]),
        .ways_lru_i(d_lru[req_index_q]),
        .hit_o(d_hit), .way_o(d_way), .lru_next_o(d_lru_nx)
    );

    lru_way_select #(.WAYS(`CS_I_WAYS)) i_sel_inst (
        .op_i(req_op_q), .req_tag_i(req_tag_q),
        .ways_tag_i(i_tag[req_index_q]), .ways_mesi_i(i_mesi[req_index_q]),
        .ways_lru_i(i_lru[req_index_q]),
        .hit_o(i_hit), .way_o(i_way), .lru_next_o(i_lru_nx)
    );

    // Fetches go to the I-cache, everything else to the D-cache
    assign sel_hit  = is_fetch ? i_hit : d_hit;
    assign cur_mesi = is_fetch ? i_mesi[req_index_q][i_way] : d_mesi[req_index_q][d_way];

    mesi_next_state mesi_inst (
        .op_i(req_op_q), .hit_i(sel_hit), .cur_i(cur_mesi), .next_o(mesi_nx)
    );

    // Take the next entry when idle, writing back, or on the last clear set
    assign dec_pop_o = dec_valid_i && (state_q == ST_IDLE || state_q == ST_UPDATE
                                       || (state_q == ST_CLEAR && clr_last));
    assign ex_done_o = (state_q == ST_UPDATE) || (state_q == ST_CLEAR && clr_last);
    assign ex_op_o   = req_op_q;
    assign ex_hit_o  = hit_q;
    assign ex_way_o  = way_q;
    assign ex_mesi_o = mesi_q;

    always_comb begin
        state_d = state_q;
        case (state_q)
            ST_LOOKUP: state_d = ST_UPDATE;
            ST_CLEAR:  if (clr_last) state_d = ST_IDLE;
            default:   state_d = ST_IDLE;
        endcase
        if (dec_pop_o)
            state_d = (dec_op_i == CMD_CLEAR) ? ST_CLEAR : ST_LOOKUP;
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q   <= ST_IDLE;
            clr_idx_q <= '0;
        end else begin
            state_q   <= state_d;
            clr_idx_q <= (state_q == ST_CLEAR) ? clr_idx_q + 1'b1 : '0;
        end
    end

    // Request held from pop until the next pop
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            req_op_q    <= CMD_RD_DATA;
            req_tag_q   <= '0;
            req_index_q <= '0;
        end else if (dec_pop_o) begin
            req_op_q    <= dec_op_i;
            req_tag_q   <= dec_tag_i;
            req_index_q <= dec_index_i;
        end
    end

    always_ff @(posedge clk) begin
        // Clear responds as a miss with no line
        if (dec_pop_o && dec_op_i == CMD_CLEAR) begin
            hit_q  <= 1'b0;
            way_q  <= '0;
            mesi_q <= MESI_I;
        end else if (state_q == ST_LOOKUP) begin
            hit_q      <= sel_hit;
            way_q      <= is_fetch ? D_WB'(i_way) : d_way;
            mesi_q     <= mesi_nx;
            d_lru_nx_q <= d_lru_nx;
            i_lru_nx_q <= i_lru_nx;
        end
    end

    // Tags only change on an access fill
    always_ff @(posedge clk) begin
        if (state_q == ST_UPDATE && is_access) begin
            if (is_fetch)
                i_tag[req_index_q][way_q[I_WB-1:0]] <= req_tag_q;
            else
                d_tag[req_index_q][way_q] <= req_tag_q;
        end
    end

    // State and ages, invalid with age equal to way after reset or clear
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            for (int s = 0; s < `CS_SETS; s++) begin
                for (int w = 0; w < `CS_D_WAYS; w++) begin
                    d_mesi[s][w] <= MESI_I;
                    d_lru[s][w]  <= `CS_LRU_BITS'(w);
                end
                for (int w = 0; w < `CS_I_WAYS; w++) begin
                    i_mesi[s][w] <= MESI_I;
                    i_lru[s][w]  <= `CS_LRU_BITS'(w);
                end
            end
        end else if (state_q == ST_CLEAR) begin
            for (int w = 0; w < `CS_D_WAYS; w++) begin
                d_mesi[clr_idx_q][w] <= MESI_I;
                d_lru[clr_idx_q][w]  <= `CS_LRU_BITS'(w);
            end
            for (int w = 0; w < `CS_I_WAYS; w++) begin
                i_mesi[clr_idx_q][w] <= MESI_I;
                i_lru[clr_idx_q][w]  <= `CS_LRU_BITS'(w);
            end
        // Snoop misses leave the set alone
        end else if (state_q == ST_UPDATE && (is_access || hit_q)) begin
            if (is_fetch) begin
                i_mesi[req_index_q][way_q[I_WB-1:0]] <= mesi_q;
                i_lru[req_index_q] <= i_lru_nx_q;
            end else begin
                d_mesi[req_index_q][way_q] <= mesi_q;
                d_lru[req_index_q] <= d_lru_nx_q;
            end
        end
    end

    a_state_legal: assert property (@(posedge clk) disable iff (!rst_n_i)
        !$isunknown(state_q) && state_q inside {ST_IDLE, ST_LOOKUP, ST_UPDATE, ST_CLEAR})
        else $error("illegal controller state");

endmodule

//--- hw/cache_stats.sv
// Registered response output and hit, miss, read and write counters
`timescale 1ns/1ps
`include "cache_sim_defines.svh"

module cache_stats import cache_sim_pkg::*; (
    input  logic                          clk,
    input  logic                          rst_n_i,
    input  logic                          ex_done_i,
    input  cmd_op_e                       ex_op_i,
    input  logic                          ex_hit_i,
    input  logic [$clog2(`CS_D_WAYS)-1:0] ex_way_i,
    input  mesi_e                         ex_mesi_i,
    output logic                          rsp_valid_o,
    output logic                          rsp_hit_o,
    output logic [$clog2(`CS_D_WAYS)-1:0] rsp_way_o,
    output mesi_e                         rsp_mesi_o,
    output logic [`CS_CNT_BITS-1:0]       hits_o,
    output logic [`CS_CNT_BITS-1:0]       misses_o,
    output logic [`CS_CNT_BITS-1:0]       reads_o,
    output logic [`CS_CNT_BITS-1:0]       writes_o
);
    logic is_access;

    // Only reads, writes and fetches count
    assign is_access = ex_op_i inside {CMD_RD_DATA, CMD_WR_DATA, CMD_FETCH};

    // Response payload
    always_ff @(posedge clk) begin
        if (ex_done_i) begin
            rsp_hit_o  <= ex_hit_i;
            rsp_way_o  <= ex_way_i;
            rsp_mesi_o <= ex_mesi_i;
        end
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            rsp_valid_o <= 1'b0;
            hits_o      <= '0;
            misses_o    <= '0;
            reads_o     <= '0;
            writes_o    <= '0;
        end else begin
            rsp_valid_o <= ex_done_i;
            if (ex_done_i && ex_op_i == CMD_CLEAR) begin
                hits_o   <= '0;
                misses_o <= '0;
                reads_o  <= '0;
                writes_o <= '0;
            end else if (ex_done_i && is_access) begin
                if (ex_hit_i)
                    hits_o <= hits_o + 1'b1;
                else
                    misses_o <= misses_o + 1'b1;
                if (ex_op_i == CMD_WR_DATA)
                    writes_o <= writes_o + 1'b1;
                else
                    reads_o <= reads_o + 1'b1;  // data read or fetch
            end
        end
    end

endmodule

//--- hw/cache_sim_top.sv
// Top level joining command queue, access controller and statistics
`timescale 1ns/1ps
`include "cache_sim_defines.svh"

module cache_sim_top import cache_sim_pkg::*; (
    input  logic                          clk,
    input  logic                          rst_n_i,
    input  logic                          cmd_valid_i,
    input  cmd_op_e                       cmd_op_i,
    input  logic [`CS_ADDR_BITS-1:0]      cmd_addr_i,
    output logic                          cmd_credit_o,
    output logic                          rsp_valid_o,
    output logic                          rsp_hit_o,
    output logic [$clog2(`CS_D_WAYS)-1:0] rsp_way_o,
    output mesi_e                         rsp_mesi_o,
    output logic [`CS_CNT_BITS-1:0]       hits_o,
    output logic [`CS_CNT_BITS-1:0]       misses_o,
    output logic [`CS_CNT_BITS-1:0]       reads_o,
    output logic [`CS_CNT_BITS-1:0]       writes_o
);
    // Decode to execute
    logic                      dec_valid;
    logic                      dec_pop;
    cmd_op_e                   dec_op;
    logic [`CS_TAG_BITS-1:0]   dec_tag;
    logic [`CS_INDEX_BITS-1:0] dec_index;

    // Execute to result
    logic                          ex_done;
    cmd_op_e                       ex_op;
    logic                          ex_hit;
    logic [$clog2(`CS_D_WAYS)-1:0] ex_way;
    mesi_e                         ex_mesi;

    cmd_decoder cmd_decoder_inst (
        .clk(clk), .rst_n_i(rst_n_i),
        .cmd_valid_i(cmd_valid_i), .cmd_op_i(cmd_op_i), .cmd_addr_i(cmd_addr_i),
        .dec_pop_i(dec_pop), .dec_valid_o(dec_valid), .dec_op_o(dec_op),
        .dec_tag_o(dec_tag), .dec_index_o(dec_index), .cmd_credit_o(cmd_credit_o)
    );

    cache_access_ctrl cache_access_ctrl_inst (
        .clk(clk), .rst_n_i(rst_n_i),
        .dec_valid_i(dec_valid), .dec_op_i(dec_op), .dec_tag_i(dec_tag),
        .dec_index_i(dec_index), .dec_pop_o(dec_pop),
        .ex_done_o(ex_done), .ex_op_o(ex_op), .ex_hit_o(ex_hit),
        .ex_way_o(ex_way), .ex_mesi_o(ex_mesi)
    );

    cache_stats cache_stats_inst (
        .clk(clk), .rst_n_i(rst_n_i),
        .ex_done_i(ex_done), .ex_op_i(ex_op), .ex_hit_i(ex_hit),
        .ex_way_i(ex_way), .ex_mesi_i(ex_mesi),
        .rsp_valid_o(rsp_valid_o), .rsp_hit_o(rsp_hit_o), .rsp_way_o(rsp_way_o),
        .rsp_mesi_o(rsp_mesi_o), .hits_o(hits_o), .misses_o(misses_o),
        .reads_o(reads_o), .writes_o(writes_o)
    );

endmodule

//--- test/cache_sim_tb.sv
// Testbench with clock, reset, LFSR stimulus, reference cache model and response checks
`timescale 1ns/1ps
`include "cache_sim_defines.svh"

module cache_sim_tb import cache_sim_pkg::*; ();
    localparam int WAIT_LIMIT = 200;

    // Expected response with the counter values after it
    typedef struct packed {
        logic                    hit;
        logic [2:0]              way;
        logic                    chk_way;
        mesi_e                   mesi;
        logic [`CS_CNT_BITS-1:0] hits;
        logic [`CS_CNT_BITS-1:0] misses;
        logic [`CS_CNT_BITS-1:0] reads;
        logic [`CS_CNT_BITS-1:0] writes;
    } exp_t;

    logic                      clk;
    logic                      rst_n_i;
    logic                      cmd_valid_i;
    cmd_op_e                   cmd_op_i;
    logic [`CS_ADDR_BITS-1:0]  cmd_addr_i;
    logic                      cmd_credit_o;
    logic                      rsp_valid_o;
    logic                      rsp_hit_o;
    logic [2:0]                rsp_way_o;
    mesi_e                     rsp_mesi_o;
    logic [`CS_CNT_BITS-1:0]   hits_o;
    logic [`CS_CNT_BITS-1:0]   misses_o;
    logic [`CS_CNT_BITS-1:0]   reads_o;
    logic [`CS_CNT_BITS-1:0]   writes_o;

    // Reference model, cache 0 is data and cache 1 is instruction
    logic [`CS_TAG_BITS-1:0] m_tag  [2][`CS_SETS][`CS_D_WAYS];
    mesi_e                   m_mesi [2][`CS_SETS][`CS_D_WAYS];
    int                      m_age  [2][`CS_SETS][`CS_D_WAYS];
    int m_hits, m_misses, m_reads, m_writes;

    exp_t        exp_q[$];
    logic [31:0] lfsr_q = 32'h4851cfe6;
    int sent = 0;
    int returned = 0;
    int responses = 0;
    int errors = 0;

    cache_sim_top cache_sim_top_inst (
        .clk(clk), .rst_n_i(rst_n_i),
        .cmd_valid_i(cmd_valid_i), .cmd_op_i(cmd_op_i), .cmd_addr_i(cmd_addr_i),
        .cmd_credit_o(cmd_credit_o), .rsp_valid_o(rsp_valid_o), .rsp_hit_o(rsp_hit_o),
        .rsp_way_o(rsp_way_o), .rsp_mesi_o(rsp_mesi_o), .hits_o(hits_o),
        .misses_o(misses_o), .reads_o(reads_o), .writes_o(writes_o)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // Taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    // One LFSR step per bit taken
    function automatic logic [31:0] draw_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], lfsr_q[31]};
            lfsr_q = lfsr_step(lfsr_q);
        end
        return v;
    endfunction

    task automatic finish_run();
        $display("commands=%0d responses=%0d errors=%0d", sent, responses, errors);
        if (errors == 0)
            $display("TEST OK");
        else
            $display("TEST FAILED");
        $finish;
    endtask

    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] exp);
        errors++;
        $display("FAIL %s got 0x%h expected 0x%h", name, got, exp);
    endtask

    // All lines invalid, age equal to way, counters zero
    task automatic model_reset();
        for (int c = 0; c < 2; c++)
            for (int s = 0; s < `CS_SETS; s++)
                for (int w = 0; w < `CS_D_WAYS; w++) begin
                    m_tag[c][s][w]  = '0;
                    m_mesi[c][s][w] = MESI_I;
                    m_age[c][s][w]  = w;
                end
        m_hits   = 0;
        m_misses = 0;
        m_reads  = 0;
        m_writes = 0;
    endtask

    // Apply one command to the model and queue its expected response
    task automatic model_cmd(input cmd_op_e op, input logic [`CS_TAG_BITS-1:0] tag,
                             input logic [`CS_INDEX_BITS-1:0] idx);
        exp_t e;
        int   c;
        int   nw;
        int   way;
        int   thr;
        e      = '0;
        e.mesi = MESI_I;
        c      = (op == CMD_FETCH) ? 1 : 0;
        nw     = c ? `CS_I_WAYS : `CS_D_WAYS;
        way    = -1;
        if (op == CMD_CLEAR) begin
            model_reset();
            e.chk_way = 1'b1;
        end else begin
            for (int w = 0; w < nw; w++)
                if (m_mesi[c][idx][w] != MESI_I && m_tag[c][idx][w] == tag)
                    way = w;
            e.hit = (way >= 0);
            // Miss picks the lowest invalid way, else the oldest
            if (!e.hit) begin
                for (int w = nw - 1; w >= 0; w--)
                    if (m_mesi[c][idx][w] == MESI_I)
                        way = w;
                if (way < 0) begin
                    way = 0;
                    for (int w = 1; w < nw; w++)
                        if (m_age[c][idx][w] > m_age[c][idx][way])
                            way = w;
                end
            end
            e.way = 3'(way);
            if (op inside {CMD_RD_DATA, CMD_WR_DATA, CMD_FETCH}) begin
                // Ways younger than the used one get older
                thr = m_age[c][idx][way];
                for (int w = 0; w < nw; w++) begin
                    if (w == way)
                        m_age[c][idx][w] = 0;
                    else if (m_age[c][idx][w] < thr)
                        m_age[c][idx][w]++;
                end
                m_tag[c][idx][way] = tag;
                if (op == CMD_WR_DATA)
                    m_mesi[c][idx][way] = MESI_M;
                else if (!e.hit)
                    m_mesi[c][idx][way] = MESI_E;
                if (e.hit)
                    m_hits++;
                else
                    m_misses++;
                if (op == CMD_WR_DATA)
                    m_writes++;
                else
                    m_reads++;
                e.chk_way = 1'b1;
            end else if (e.hit) begin
                if (op == CMD_SNP_INV)
                    m_mesi[c][idx][way] = MESI_I;
                else if (m_mesi[c][idx][way] inside {MESI_M, MESI_E})
                    m_mesi[c][idx][way] = MESI_S;
                e.chk_way = 1'b1;
            end
            // Snoop misses report no line
            if (e.chk_way)
                e.mesi = m_mesi[c][idx][way];
        end
        e.hits   = `CS_CNT_BITS'(m_hits);
        e.misses = `CS_CNT_BITS'(m_misses);
        e.reads  = `CS_CNT_BITS'(m_reads);
        e.writes = `CS_CNT_BITS'(m_writes);
        exp_q.push_back(e);
    endtask

    // Called on a falling edge, returns one falling edge after the send
    task automatic send_cmd(input cmd_op_e op, input logic [`CS_TAG_BITS-1:0] tag,
                            input logic [`CS_INDEX_BITS-1:0] idx);
        int         tmo;
        logic [5:0] offs;
        tmo  = 0;
        offs = 6'(draw_bits(6));
        while (sent - returned >= `CS_CMD_CREDITS && tmo < WAIT_LIMIT) begin
            @(negedge clk);
            tmo++;
        end
        if (tmo >= WAIT_LIMIT) begin
            errors++;
            $display("timeout waiting for a command credit");
            finish_run();
        end else begin
            cmd_valid_i = 1'b1;
            cmd_op_i    = op;
            cmd_addr_i  = {tag, idx, offs};
            sent++;
            model_cmd(op, tag, idx);
            @(negedge clk);
            cmd_valid_i = 1'b0;
        end
    endtask

    // Drain until every expected response is back
    task automatic wait_idle();
        int tmo;
        tmo = 0;
        while (exp_q.size() != 0 && tmo < WAIT_LIMIT) begin
            @(negedge clk);
            tmo++;
        end
        if (tmo >= WAIT_LIMIT) begin
            errors++;
            $display("timeout waiting for outstanding responses");
            finish_run();
        end
    endtask

    // Credit and response checks, on values held since the previous edge
    always @(posedge clk) begin
        exp_t e;
        if (rst_n_i) begin
            if (cmd_credit_o)
                returned++;
            a_credit_bound: assert (returned <= sent && sent - returned <= `CS_CMD_CREDITS)
                else begin
                    errors++;
                    $display("credits out of range with %0d sent and %0d returned",
                             sent, returned);
                end
            if (rsp_valid_o) begin
                responses++;
                if (exp_q.size() == 0) begin
                    errors++;
                    $display("response arrived with no command outstanding");
                end else begin
                    e = exp_q.pop_front();
                    a_rsp_hit: assert (rsp_hit_o == e.hit)
                        else report_mismatch("rsp_hit_o", 32'(rsp_hit_o), 32'(e.hit));
                    a_rsp_way: assert (!e.chk_way || rsp_way_o == e.way)
                        else report_mismatch("rsp_way_o", 32'(rsp_way_o), 32'(e.way));
                    a_rsp_mesi: assert (rsp_mesi_o == e.mesi)
                        else report_mismatch("rsp_mesi_o", 32'(rsp_mesi_o), 32'(e.mesi));
                    a_hits: assert (hits_o == e.hits)
                        else report_mismatch("hits_o", 32'(hits_o), 32'(e.hits));
                    a_misses: assert (misses_o == e.misses)
                        else report_mismatch("misses_o", 32'(misses_o), 32'(e.misses));
                    a_reads: assert (reads_o == e.reads)
                        else report_mismatch("reads_o", 32'(reads_o), 32'(e.reads));
                    a_writes: assert (writes_o == e.writes)
                        else report_mismatch("writes_o", 32'(writes_o), 32'(e.writes));
                end
            end
        end
    end

    initial begin
        rst_n_i     = 1'b0;
        cmd_valid_i = 1'b0;
        cmd_op_i    = CMD_RD_DATA;
        cmd_addr_i  = '0;
        model_reset();
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst_n_i = 1'b1;

        // Read miss, read hit, write hit on set 3
        send_cmd(CMD_RD_DATA, 22'h100, 4'd3);
        send_cmd(CMD_RD_DATA, 22'h100, 4'd3);
        send_cmd(CMD_WR_DATA, 22'h100, 4'd3);
        send_cmd(CMD_RD_DATA, 22'h101, 4'd3);

        // Snoops on an M line and an E line, then misses
        send_cmd(CMD_SNP_RD, 22'h100, 4'd3);
        send_cmd(CMD_SNP_RD, 22'h101, 4'd3);
        send_cmd(CMD_SNP_INV, 22'h100, 4'd3);
        send_cmd(CMD_SNP_INV, 22'h100, 4'd3);
        send_cmd(CMD_SNP_RD, 22'h1ff, 4'd3);
        send_cmd(CMD_RD_DATA, 22'h101, 4'd3);
        send_cmd(CMD_RD_DATA, 22'h100, 4'd3);
        wait_idle();

        // Back to back burst against the credit limit
        for (int i = 0; i < 12; i++)
            send_cmd(CMD_RD_DATA, 22'(32'h200 + draw_bits(4)), 4'(12 + draw_bits(2)));
        wait_idle();

        // Fill all eight data ways of set 5, touch way 0, then evict
        for (int i = 0; i < 8; i++)
            send_cmd(CMD_RD_DATA, 22'(32'h300 + i), 4'd5);
        send_cmd(CMD_RD_DATA, 22'h300, 4'd5);
        send_cmd(CMD_RD_DATA, 22'h308, 4'd5);
        send_cmd(CMD_RD_DATA, 22'h301, 4'd5);
        // Instruction set 5 evicts after four tags
        for (int i = 0; i < 5; i++)
            send_cmd(CMD_FETCH, 22'(32'h300 + i), 4'd5);
        send_cmd(CMD_FETCH, 22'h300, 4'd5);
        send_cmd(CMD_RD_DATA, 22'h302, 4'd5);
        wait_idle();

        // Random mix over a small tag pool and four sets
        for (int i = 0; i < 200; i++) begin
            case (draw_bits(3))
                0, 1:    send_cmd(CMD_RD_DATA, 22'(32'h200 + draw_bits(4)), 4'(draw_bits(2)));
                2, 3:    send_cmd(CMD_WR_DATA, 22'(32'h200 + draw_bits(4)), 4'(draw_bits(2)));
                4, 5:    send_cmd(CMD_FETCH, 22'(32'h200 + draw_bits(4)), 4'(draw_bits(2)));
                6:       send_cmd(CMD_SNP_INV, 22'(32'h200 + draw_bits(4)), 4'(draw_bits(2)));
                default: send_cmd(CMD_SNP_RD, 22'(32'h200 + draw_bits(4)), 4'(draw_bits(2)));
            endcase
        end
        wait_idle();

        // Clear, then an earlier line misses and refills
        send_cmd(CMD_CLEAR, 22'h0, 4'd0);
        send_cmd(CMD_RD_DATA, 22'h100, 4'd3);
        send_cmd(CMD_RD_DATA, 22'h100, 4'd3);
        wait_idle();

        // Each credit returns before its response, so all are back by now
        a_credits_back: assert (returned == sent)
            else begin
                errors++;
                $display("credit returns do not match commands sent");
            end
        finish_run();
    end

endmodule

//--- cache_sim.f
+incdir+hw
hw/cache_sim_pkg.sv
hw/cmd_decoder.sv
hw/lru_way_select.sv
hw/mesi_next_state.sv
hw/cache_access_ctrl.sv
hw/cache_stats.sv
hw/cache_sim_top.sv
test/cache_sim_tb.sv
